//--- fpu_pkg.sv
package fpu_pkg;

  localparam int fp_width       = 32;
  localparam int reg_addr_width = 5;
  localparam int wb_addr_width  = 4;

  typedef logic [fp_width-1:0]       fp_word_t;
  typedef logic [fp_width-1:0]       instr_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;
  typedef logic [wb_addr_width-1:0]  wb_addr_t;

  typedef enum logic [3:0] {
    op_none,
    op_fsgnj,
    op_fsgnjn,
    op_fsgnjx,
    op_fmin,
    op_fmax,
    op_feq,
    op_flt,
    op_fle,
    op_fclass,
    op_fmv_f2i,
    op_fmv_i2f
  } fp_op_e;

  localparam logic [6:0] opcode_fp = 7'h53;

  // Matched against funct7[6:2]
  localparam logic [4:0] funct_fsgnj   = 5'b00100;
  localparam logic [4:0] funct_fminmax = 5'b00101;
  localparam logic [4:0] funct_fcomp   = 5'b10100;
  localparam logic [4:0] funct_fmv_f2i = 5'b11100;
  localparam logic [4:0] funct_fmv_i2f = 5'b11110;

  localparam logic [1:0] fmt_single = 2'b00;

  // rm field sub-operation selectors
  localparam logic [2:0] rm_sgnj_j  = 3'd0;
  localparam logic [2:0] rm_sgnj_n  = 3'd1;
  localparam logic [2:0] rm_sgnj_x  = 3'd2;
  localparam logic [2:0] rm_min     = 3'd0;
  localparam logic [2:0] rm_max     = 3'd1;
  localparam logic [2:0] rm_fle     = 3'd0;
  localparam logic [2:0] rm_flt     = 3'd1;
  localparam logic [2:0] rm_feq     = 3'd2;
  localparam logic [2:0] rm_fmv     = 3'd0;
  localparam logic [2:0] rm_fclass  = 3'd1;

  localparam fp_word_t canonical_nan = 32'h7FC0_0000;

  // Bus register map
  localparam wb_addr_t reg_instr  = 4'h0; // A write issues an instruction
  localparam wb_addr_t reg_xsrc   = 4'h4;
  localparam wb_addr_t reg_xres   = 4'h8; // Read only
  localparam wb_addr_t reg_status = 4'hC;

  localparam int status_illegal_bit = 0;
  localparam int status_busy_bit    = 1;

endpackage

//--- fpu_result_if.sv
interface fpu_result_if;

  logic                fp_wren;
  logic                x_wren;
  fpu_pkg::reg_addr_t  waddr;
  fpu_pkg::fp_word_t   wdata;

  // Driven by the writeback stage
  modport src (output fp_wren, output x_wren, output waddr, output wdata);

  modport rf (input fp_wren, input waddr, input wdata);

  modport fwd (input fp_wren, input x_wren, input waddr, input wdata);

endinterface

//--- fpu_decode.sv
module fpu_decode (
  input  fpu_pkg::instr_t    instr_i,
  output fpu_pkg::reg_addr_t raddr1_o,
  output fpu_pkg::reg_addr_t raddr2_o,
  output fpu_pkg::reg_addr_t raddr3_o,
  output fpu_pkg::reg_addr_t waddr_o,
  output logic               rden1_o,
  output logic               rden2_o,
  output logic               rden3_o,
  output logic               fp_wren_o,
  output logic               x_wren_o,
  output fpu_pkg::fp_op_e    op_o,
  output logic               legal_o
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] rm;

  assign opcode   = instr_i[6:0];
  assign funct7   = instr_i[31:25];
  assign rm       = instr_i[14:12];
  assign waddr_o  = instr_i[11:7];
  assign raddr1_o = instr_i[19:15];
  assign raddr2_o = instr_i[24:20];
  assign raddr3_o = instr_i[31:27];
  assign rden3_o  = 1'b0; // No three-operand ops left

  always_comb begin
    rden1_o   = 1'b0;
    rden2_o   = 1'b0;
    fp_wren_o = 1'b0;
    x_wren_o  = 1'b0;
    op_o      = fpu_pkg::op_none;
    legal_o   = 1'b1;

    if (opcode != fpu_pkg::opcode_fp || funct7[1:0] != fpu_pkg::fmt_single) begin
      legal_o = 1'b0;
    end else begin
      case (funct7[6:2])
        fpu_pkg::funct_fsgnj : begin
          fp_wren_o = 1'b1;
          rden1_o   = 1'b1;
          rden2_o   = 1'b1;
          case (rm)
            fpu_pkg::rm_sgnj_j : op_o = fpu_pkg::op_fsgnj;
            fpu_pkg::rm_sgnj_n : op_o = fpu_pkg::op_fsgnjn;
            fpu_pkg::rm_sgnj_x : op_o = fpu_pkg::op_fsgnjx;
            default            : legal_o = 1'b0;
          endcase
        end
        fpu_pkg::funct_fminmax : begin
          fp_wren_o = 1'b1;
          rden1_o   = 1'b1;
          rden2_o   = 1'b1;
          case (rm)
            fpu_pkg::rm_min : op_o = fpu_pkg::op_fmin;
            fpu_pkg::rm_max : op_o = fpu_pkg::op_fmax;
            default         : legal_o = 1'b0;
          endcase
        end
        fpu_pkg::funct_fcomp : begin
          x_wren_o = 1'b1; // Compare result goes to integer side
          rden1_o  = 1'b1;
          rden2_o  = 1'b1;
          case (rm)
            fpu_pkg::rm_feq : op_o = fpu_pkg::op_feq;
            fpu_pkg::rm_flt : op_o = fpu_pkg::op_flt;
            fpu_pkg::rm_fle : op_o = fpu_pkg::op_fle;
            default         : legal_o = 1'b0;
          endcase
        end
        fpu_pkg::funct_fmv_f2i : begin
          x_wren_o = 1'b1;
          rden1_o  = 1'b1;
          if (raddr2_o != '0) begin
            legal_o = 1'b0;
          end else if (rm == fpu_pkg::rm_fmv) begin
            op_o = fpu_pkg::op_fmv_f2i;
          end else if (rm == fpu_pkg::rm_fclass) begin
            op_o = fpu_pkg::op_fclass;
          end else begin
            legal_o = 1'b0;
          end
        end
        fpu_pkg::funct_fmv_i2f : begin
          fp_wren_o = 1'b1; // Source is the xsrc register
          if (raddr2_o != '0 || rm != fpu_pkg::rm_fmv) begin
            legal_o = 1'b0;
          end else begin
            op_o = fpu_pkg::op_fmv_i2f;
          end
        end
        default : legal_o = 1'b0;
      endcase
    end

    if (!legal_o) begin
      rden1_o   = 1'b0;
      rden2_o   = 1'b0;
      fp_wren_o = 1'b0;
      x_wren_o  = 1'b0;
      op_o      = fpu_pkg::op_none;
    end
  end

endmodule

//--- fpu_register.sv
module fpu_register #(
  parameter int NUM_FP_REGS = 32
) (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               rd_en_i,
  input  fpu_pkg::reg_addr_t raddr1_i,
  input  fpu_pkg::reg_addr_t raddr2_i,
  input  fpu_pkg::reg_addr_t raddr3_i,
  fpu_result_if.rf           wr,
  output fpu_pkg::fp_word_t  rdata1_o,
  output fpu_pkg::fp_word_t  rdata2_o,
  output fpu_pkg::fp_word_t  rdata3_o
);

  localparam int addr_w = $clog2(NUM_FP_REGS);

  fpu_pkg::fp_word_t  fp_reg_file [NUM_FP_REGS];
  fpu_pkg::reg_addr_t raddr1_q;
  fpu_pkg::reg_addr_t raddr2_q;
  fpu_pkg::reg_addr_t raddr3_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      raddr1_q <= '0;
      raddr2_q <= '0;
      raddr3_q <= '0;
      for (int i = 0; i < NUM_FP_REGS; i++) begin
        fp_reg_file[i] <= '0;
      end
    end else begin
      if (rd_en_i) begin // Addresses follow the issued instruction
        raddr1_q <= raddr1_i;
        raddr2_q <= raddr2_i;
        raddr3_q <= raddr3_i;
      end
      if (wr.fp_wren) begin
        fp_reg_file[wr.waddr[addr_w-1:0]] <= wr.wdata;
      end
    end
  end

  assign rdata1_o = fp_reg_file[raddr1_q[addr_w-1:0]];
  assign rdata2_o = fp_reg_file[raddr2_q[addr_w-1:0]];
  assign rdata3_o = fp_reg_file[raddr3_q[addr_w-1:0]];

endmodule

//--- fpu_forwarding.sv
module fpu_forwarding (
  input  fpu_pkg::reg_addr_t raddr1_i,
  input  fpu_pkg::reg_addr_t raddr2_i,
  input  fpu_pkg::reg_addr_t raddr3_i,
  input  logic               rden1_i,
  input  logic               rden2_i,
  input  logic               rden3_i,
  input  fpu_pkg::fp_word_t  rdata1_i,
  input  fpu_pkg::fp_word_t  rdata2_i,
  input  fpu_pkg::fp_word_t  rdata3_i,
  fpu_result_if.fwd          wb,
  output fpu_pkg::fp_word_t  data1_o,
  output fpu_pkg::fp_word_t  data2_o,
  output fpu_pkg::fp_word_t  data3_o
);

  always_comb begin
    data1_o = '0;
    data2_o = '0;
    data3_o = '0;
    if (rden1_i) begin
      data1_o = (wb.fp_wren && raddr1_i == wb.waddr) ? wb.wdata : rdata1_i;
    end
    if (rden2_i) begin
      data2_o = (wb.fp_wren && raddr2_i == wb.waddr) ? wb.wdata : rdata2_i;
    end
    if (rden3_i) begin
      data3_o = (wb.fp_wren && raddr3_i == wb.waddr) ? wb.wdata : rdata3_i;
    end
  end

endmodule

//--- fpu_execute.sv
module fpu_execute (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               issue_i,
  input  fpu_pkg::fp_op_e    op_i,
  input  fpu_pkg::reg_addr_t waddr_i,
  input  logic               fp_wren_i,
  input  logic               x_wren_i,
  input  fpu_pkg::reg_addr_t raddr1_i,
  input  fpu_pkg::reg_addr_t raddr2_i,
  input  fpu_pkg::reg_addr_t raddr3_i,
  input  logic               rden1_i,
  input  logic               rden2_i,
  input  logic               rden3_i,
  input  logic               legal_i,
  input  fpu_pkg::fp_word_t  xsrc_i,
  output logic               illegal_o,
  output logic               busy_o,
  input  fpu_pkg::fp_word_t  data1_i,
  input  fpu_pkg::fp_word_t  data2_i,
  output fpu_pkg::reg_addr_t ex_raddr1_o,
  output fpu_pkg::reg_addr_t ex_raddr2_o,
  output fpu_pkg::reg_addr_t ex_raddr3_o,
  output logic               ex_rden1_o,
  output logic               ex_rden2_o,
  output logic               ex_rden3_o,
  fpu_result_if.src          res
);

  logic               ex_valid;
  logic               wb_valid;
  fpu_pkg::fp_op_e    ex_op;
  fpu_pkg::reg_addr_t ex_waddr;
  logic               ex_fp_wren;
  logic               ex_x_wren;
  fpu_pkg::fp_word_t  ex_result;

  logic       a_nan, b_nan, any_nan;
  logic       a_exp_max, a_exp_zero, a_man_zero;
  logic       both_zero, lt_total, eq;
  logic [9:0] class_mask;

  assign illegal_o = issue_i && !legal_i; // Illegal words never enter a stage
  assign busy_o    = ex_valid || wb_valid;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ex_valid    <= 1'b0;
      ex_fp_wren  <= 1'b0;
      ex_x_wren   <= 1'b0;
      ex_rden1_o  <= 1'b0;
      ex_rden2_o  <= 1'b0;
      ex_rden3_o  <= 1'b0;
      wb_valid    <= 1'b0;
      res.fp_wren <= 1'b0;
      res.x_wren  <= 1'b0;
    end else begin
      ex_valid <= issue_i && legal_i;
      if (issue_i && legal_i) begin
        ex_fp_wren <= fp_wren_i;
        ex_x_wren  <= x_wren_i;
        ex_rden1_o <= rden1_i;
        ex_rden2_o <= rden2_i;
        ex_rden3_o <= rden3_i;
      end
      wb_valid    <= ex_valid;
      res.fp_wren <= ex_valid && ex_fp_wren;
      res.x_wren  <= ex_valid && ex_x_wren;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_i && legal_i) begin
      ex_op       <= op_i;
      ex_waddr    <= waddr_i;
      ex_raddr1_o <= raddr1_i;
      ex_raddr2_o <= raddr2_i;
      ex_raddr3_o <= raddr3_i;
    end
    if (ex_valid) begin
      res.waddr <= ex_waddr;
      res.wdata <= ex_result;
    end
  end

  assign a_exp_max  = &data1_i[30:23];
  assign a_exp_zero = ~|data1_i[30:23];
  assign a_man_zero = ~|data1_i[22:0];
  assign a_nan      = a_exp_max && !a_man_zero;
  assign b_nan      = (&data2_i[30:23]) && (|data2_i[22:0]);
  assign any_nan    = a_nan || b_nan;
  assign both_zero  = (data1_i[30:0] == '0) && (data2_i[30:0] == '0);
  assign eq         = (data1_i == data2_i) || both_zero;

  // Total order with -0 below +0
  always_comb begin
    if (data1_i[31] != data2_i[31]) begin
      lt_total = data1_i[31];
    end else if (data1_i[31]) begin
      lt_total = data2_i[30:0] < data1_i[30:0];
    end else begin
      lt_total = data1_i[30:0] < data2_i[30:0];
    end
  end

  always_comb begin
    class_mask = '0;
    if (a_nan) begin
      class_mask[data1_i[22] ? 9 : 8] = 1'b1; // Quiet bit set
    end else if (a_exp_max) begin
      class_mask[data1_i[31] ? 0 : 7] = 1'b1;
    end else if (a_exp_zero && a_man_zero) begin
      class_mask[data1_i[31] ? 3 : 4] = 1'b1;
    end else if (a_exp_zero) begin
      class_mask[data1_i[31] ? 2 : 5] = 1'b1;
    end else begin
      class_mask[data1_i[31] ? 1 : 6] = 1'b1;
    end
  end

  always_comb begin
    ex_result = '0;
    case (ex_op)
      fpu_pkg::op_fsgnj  : ex_result = {data2_i[31], data1_i[30:0]};
      fpu_pkg::op_fsgnjn : ex_result = {~data2_i[31], data1_i[30:0]};
      fpu_pkg::op_fsgnjx : ex_result = {data1_i[31] ^ data2_i[31], data1_i[30:0]};
      fpu_pkg::op_fmin, fpu_pkg::op_fmax : begin
        if (a_nan && b_nan) begin
          ex_result = fpu_pkg::canonical_nan;
        end else if (a_nan) begin
          ex_result = data2_i;
        end else if (b_nan) begin
          ex_result = data1_i;
        end else if (lt_total ^ (ex_op == fpu_pkg::op_fmax)) begin
          ex_result = data1_i;
        end else begin
          ex_result = data2_i;
        end
      end
      fpu_pkg::op_feq     : ex_result = {31'b0, !any_nan && eq};
      fpu_pkg::op_flt     : ex_result = {31'b0, !any_nan && lt_total && !both_zero};
      fpu_pkg::op_fle     : ex_result = {31'b0, !any_nan && (lt_total || eq)};
      fpu_pkg::op_fclass  : ex_result = {22'b0, class_mask};
      fpu_pkg::op_fmv_f2i : ex_result = data1_i;
      fpu_pkg::op_fmv_i2f : ex_result = xsrc_i;
      default             : ex_result = '0;
    endcase
  end

endmodule

//--- fpu_wb_slave.sv
module fpu_wb_slave (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  fpu_pkg::wb_addr_t wb_adr_i,
  input  fpu_pkg::fp_word_t wb_dat_i,
  output fpu_pkg::fp_word_t wb_dat_o,
  output logic              wb_ack_o,
  output logic              issue_o,
  output fpu_pkg::instr_t   instr_o,
  output fpu_pkg::fp_word_t xsrc_o,
  input  logic              illegal_i,
  input  logic              busy_i,
  fpu_result_if.fwd         res
);

  logic              req;
  logic              xres_stall;
  logic              accept;
  logic              wr_instr;
  logic              wr_xsrc;
  logic              wr_status;
  logic              illegal_flag;
  fpu_pkg::fp_word_t xres;
  fpu_pkg::fp_word_t rdata;

  assign req        = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign xres_stall = !wb_we_i && wb_adr_i == fpu_pkg::reg_xres && busy_i; // Wait for idle
  assign accept     = req && !xres_stall;
  assign wr_instr   = accept && wb_we_i && wb_adr_i == fpu_pkg::reg_instr;
  assign wr_xsrc    = accept && wb_we_i && wb_adr_i == fpu_pkg::reg_xsrc;
  assign wr_status  = accept && wb_we_i && wb_adr_i == fpu_pkg::reg_status;

  always_comb begin
    rdata = '0;
    case (wb_adr_i)
      fpu_pkg::reg_xsrc : rdata = xsrc_o;
      fpu_pkg::reg_xres : rdata = xres;
      fpu_pkg::reg_status : begin
        rdata[fpu_pkg::status_illegal_bit] = illegal_flag;
        rdata[fpu_pkg::status_busy_bit]    = busy_i;
      end
      default : rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wb_ack_o     <= 1'b0;
      issue_o      <= 1'b0;
      xsrc_o       <= '0;
      xres         <= '0;
      illegal_flag <= 1'b0;
    end else begin
      wb_ack_o <= accept;
      issue_o  <= wr_instr; // Lines up with the ack
      if (wr_xsrc) begin
        xsrc_o <= wb_dat_i;
      end
      if (res.x_wren) begin
        xres <= res.wdata;
      end
      if (illegal_i) begin
        illegal_flag <= 1'b1;
      end else if (wr_status) begin
        illegal_flag <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_instr) begin
      instr_o <= wb_dat_i;
    end
    if (accept && !wb_we_i) begin
      wb_dat_o <= rdata;
    end
  end

endmodule

//--- fpu_top.sv
module fpu_top #(
  parameter int NUM_FP_REGS = 32
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  fpu_pkg::wb_addr_t wb_adr_i,
  input  fpu_pkg::fp_word_t wb_dat_i,
  output fpu_pkg::fp_word_t wb_dat_o,
  output logic              wb_ack_o
);

  logic               issue, illegal, busy, legal;
  fpu_pkg::instr_t    instr;
  fpu_pkg::fp_word_t  xsrc;
  fpu_pkg::reg_addr_t raddr1, raddr2, raddr3, waddr;
  logic               rden1, rden2, rden3, fp_wren, x_wren;
  fpu_pkg::fp_op_e    op;
  fpu_pkg::reg_addr_t ex_raddr1, ex_raddr2, ex_raddr3;
  logic               ex_rden1, ex_rden2, ex_rden3;
  fpu_pkg::fp_word_t  rdata1, rdata2, rdata3;
  fpu_pkg::fp_word_t  data1, data2;

  fpu_result_if result_bus ();

  fpu_wb_slave fpu_wb_slave_i (
    .clk, .rst_n_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o, .issue_o(issue), .instr_o(instr), .xsrc_o(xsrc),
    .illegal_i(illegal), .busy_i(busy), .res(result_bus.fwd)
  );

  fpu_decode fpu_decode_i (
    .instr_i(instr), .raddr1_o(raddr1), .raddr2_o(raddr2), .raddr3_o(raddr3),
    .waddr_o(waddr), .rden1_o(rden1), .rden2_o(rden2), .rden3_o(rden3),
    .fp_wren_o(fp_wren), .x_wren_o(x_wren), .op_o(op), .legal_o(legal)
  );

  fpu_register #(.NUM_FP_REGS(NUM_FP_REGS)) fpu_register_i (
    .clk, .rst_n_i, .rd_en_i(issue), .raddr1_i(raddr1), .raddr2_i(raddr2),
    .raddr3_i(raddr3), .wr(result_bus.rf), .rdata1_o(rdata1), .rdata2_o(rdata2),
    .rdata3_o(rdata3)
  );

  fpu_forwarding fpu_forwarding_i (
    .raddr1_i(ex_raddr1), .raddr2_i(ex_raddr2), .raddr3_i(ex_raddr3),
    .rden1_i(ex_rden1), .rden2_i(ex_rden2), .rden3_i(ex_rden3),
    .rdata1_i(rdata1), .rdata2_i(rdata2), .rdata3_i(rdata3),
    .wb(result_bus.fwd), .data1_o(data1), .data2_o(data2), .data3_o()
  );

  fpu_execute fpu_execute_i (
    .clk, .rst_n_i, .issue_i(issue), .op_i(op), .waddr_i(waddr),
    .fp_wren_i(fp_wren), .x_wren_i(x_wren), .raddr1_i(raddr1), .raddr2_i(raddr2),
    .raddr3_i(raddr3), .rden1_i(rden1), .rden2_i(rden2), .rden3_i(rden3),
    .legal_i(legal), .xsrc_i(xsrc), .illegal_o(illegal), .busy_o(busy),
    .data1_i(data1), .data2_i(data2), .ex_raddr1_o(ex_raddr1), .ex_raddr2_o(ex_raddr2),
    .ex_raddr3_o(ex_raddr3), .ex_rden1_o(ex_rden1), .ex_rden2_o(ex_rden2),
    .ex_rden3_o(ex_rden3), .res(result_bus.src)
  );

endmodule

//--- tb_fpu.sv
module tb_fpu;

  localparam int clk_period  = 100;
  localparam int ack_timeout = 20;

  localparam logic [6:0] op_fp      = 7'h53;
  localparam logic [6:0] op_load_fp = 7'h07;
  localparam logic [6:0] f7_sgnj    = 7'h10;
  localparam logic [6:0] f7_minmax  = 7'h14;
  localparam logic [6:0] f7_cmp     = 7'h50;
  localparam logic [6:0] f7_mv_x    = 7'h70; // Also fclass with rm 1
  localparam logic [6:0] f7_mv_f    = 7'h78;
  localparam logic [6:0] f7_fadd    = 7'h00;
  localparam logic [6:0] f7_unused  = 7'h7C;

  logic              clk;
  logic              rst_n_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  fpu_pkg::wb_addr_t wb_adr_i;
  logic [31:0]       wb_dat_i;
  logic [31:0]       wb_dat_o;
  logic              wb_ack_o;

  int          checks;
  int          errors;
  int          test_start;

  fpu_top #(.NUM_FP_REGS(32)) fpu_top_i (
    .clk, .rst_n_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s expected %08h got %08h", name, expected, actual);
    end
  endtask

  // Starts on a falling edge and returns on the one that sees the ack
  task automatic wb_write(input fpu_pkg::wb_addr_t adr, input logic [31:0] data);
    int cycles;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = data;
    cycles   = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!wb_ack_o && cycles < ack_timeout);
    if (!wb_ack_o) begin
      errors++;
      $display("Timeout: no ack for the write to address %h", adr);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_read(input fpu_pkg::wb_addr_t adr, output logic [31:0] data);
    int cycles;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr;
    cycles   = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!wb_ack_o && cycles < ack_timeout);
    data = wb_dat_o;
    if (!wb_ack_o) begin
      errors++;
      $display("Timeout: no ack for the read of address %h", adr);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  function automatic logic [31:0] fp_instr(input logic [6:0] funct7, input logic [2:0] rm,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {funct7, rs2, rs1, rm, rd, op_fp};
  endfunction

  task automatic issue_instr(input logic [31:0] instr);
    wb_write(fpu_pkg::reg_instr, instr);
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    wb_write(fpu_pkg::reg_xsrc, value);
    issue_instr(fp_instr(f7_mv_f, 3'd0, rd, 5'd0, 5'd0));
  endtask

  task automatic read_reg(input logic [4:0] rs, output logic [31:0] value);
    issue_instr(fp_instr(f7_mv_x, 3'd0, 5'd0, rs, 5'd0));
    wb_read(fpu_pkg::reg_xres, value);
  endtask

  function automatic logic is_nan(input logic [31:0] x);
    return x[30:23] == 8'hFF && x[22:0] != '0;
  endfunction

  function automatic logic both_zero(input logic [31:0] a, input logic [31:0] b);
    return a[30:0] == '0 && b[30:0] == '0;
  endfunction

  // Unsigned key that sorts like the value with -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : (x | 32'h8000_0000);
  endfunction

  function automatic logic [31:0] ref_sgnj(input logic [2:0] rm, input logic [31:0] a,
                                           input logic [31:0] b);
    logic sign;
    case (rm)
      3'd0    : sign = b[31];
      3'd1    : sign = !b[31];
      default : sign = a[31] ^ b[31];
    endcase
    return {sign, a[30:0]};
  endfunction

  function automatic logic [31:0] ref_minmax(input logic want_max, input logic [31:0] a,
                                             input logic [31:0] b);
    logic a_smaller;
    a_smaller = order_key(a) < order_key(b);
    if (is_nan(a) && is_nan(b)) return 32'h7FC0_0000;
    if (is_nan(a)) return b;
    if (is_nan(b)) return a;
    if (want_max) return a_smaller ? b : a;
    return a_smaller ? a : b;
  endfunction

  function automatic logic [31:0] ref_compare(input logic [2:0] rm, input logic [31:0] a,
                                              input logic [31:0] b);
    logic res;
    if (is_nan(a) || is_nan(b)) begin
      res = 1'b0;
    end else if (rm == 3'd2) begin
      res = a == b || both_zero(a, b);
    end else if (rm == 3'd1) begin
      res = order_key(a) < order_key(b) && !both_zero(a, b);
    end else begin
      res = order_key(a) <= order_key(b) || both_zero(a, b);
    end
    return {31'b0, res};
  endfunction

  function automatic logic [31:0] ref_fclass(input logic [31:0] a);
    int bit_idx;
    if (is_nan(a)) bit_idx = a[22] ? 9 : 8;
    else if (a[30:23] == 8'hFF) bit_idx = a[31] ? 0 : 7;
    else if (a[30:0] == '0) bit_idx = a[31] ? 3 : 4;
    else if (a[30:23] == 8'h00) bit_idx = a[31] ? 2 : 5;
    else bit_idx = a[31] ? 1 : 6;
    return 32'd1 << bit_idx;
  endfunction

  task automatic run_fp_op(input logic [6:0] funct7, input logic [2:0] rm,
                           input logic [31:0] a, input logic [31:0] b,
                           output logic [31:0] result);
    load_reg(5'd1, a);
    load_reg(5'd2, b);
    issue_instr(fp_instr(funct7, rm, 5'd3, 5'd1, 5'd2));
    read_reg(5'd3, result);
  endtask

  task automatic report_test(input string name);
    $display("test %-18s %s, %0d errors", name,
             (errors == test_start) ? "ok" : "failed", errors - test_start);
  endtask

  task automatic test_move_round_trip();
    logic [31:0] model [32];
    bit          written [32];
    logic [4:0]  rd;
    logic [31:0] value;
    logic [31:0] got;
    test_start = errors;
    for (int r = 28; r < 32; r++) begin // Untouched since reset
      read_reg(5'(r), got);
      check_word($sformatf("f%0d after reset", r), 32'h0, got);
    end
    for (int i = 0; i < 12; i++) begin
      rd    = 5'($urandom_range(31, 0));
      value = $urandom;
      load_reg(rd, value);
      model[rd]   = value;
      written[rd] = 1'b1;
    end
    for (int r = 0; r < 32; r++) begin
      if (written[r]) begin
        read_reg(5'(r), got);
        check_word($sformatf("f%0d", r), model[r], got);
      end
    end
    report_test("move_round_trip");
  endtask

  task automatic test_sign_injection();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] got;
    test_start = errors;
    for (int i = 0; i < 4; i++) begin
      for (int rm = 0; rm < 3; rm++) begin
        a = $urandom;
        b = $urandom;
        run_fp_op(f7_sgnj, 3'(rm), a, b, got);
        check_word($sformatf("fsgnj rm%0d", rm), ref_sgnj(3'(rm), a, b), got);
      end
    end
    report_test("sign_injection");
  endtask

  task automatic test_min_max();
    logic [31:0] pair_a [6] = '{32'h0000_0000, 32'h8000_0000, 32'h7FC0_0000,
                                32'h3F80_0000, 32'h7F80_0001, 32'hFF80_0000};
    logic [31:0] pair_b [6] = '{32'h8000_0000, 32'h0000_0000, 32'h3F80_0000,
                                32'h7FA0_0000, 32'hFFC0_0001, 32'h7F80_0000};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] got;
    test_start = errors;
    for (int i = 0; i < 10; i++) begin
      a = (i < 6) ? pair_a[i] : $urandom;
      b = (i < 6) ? pair_b[i] : $urandom;
      run_fp_op(f7_minmax, 3'd0, a, b, got);
      check_word("fmin", ref_minmax(1'b0, a, b), got);
      run_fp_op(f7_minmax, 3'd1, a, b, got);
      check_word("fmax", ref_minmax(1'b1, a, b), got);
    end
    report_test("min_max");
  endtask

  task automatic test_compare_classify();
    logic [31:0] pair_a [6] = '{32'h3F80_0000, 32'h0000_0000, 32'h3F80_0000,
                                32'hBF80_0000, 32'h7FC0_0000, 32'h3F80_0000};
    logic [31:0] pair_b [6] = '{32'h3F80_0000, 32'h8000_0000, 32'h4000_0000,
                                32'hC000_0000, 32'h3F80_0000, 32'h7F80_0001};
    logic [31:0] classes [10] = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001,
                                  32'h8000_0000, 32'h0000_0000, 32'h0040_0000,
                                  32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001,
                                  32'h7FC0_0000};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] got;
    test_start = errors;
    for (int i = 0; i < 10; i++) begin
      a = (i < 6) ? pair_a[i] : $urandom;
      b = (i < 6) ? pair_b[i] : $urandom;
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      for (int rm = 0; rm < 3; rm++) begin // fle, flt, feq
        issue_instr(fp_instr(f7_cmp, 3'(rm), 5'd0, 5'd1, 5'd2));
        wb_read(fpu_pkg::reg_xres, got);
        check_word($sformatf("compare rm%0d", rm), ref_compare(3'(rm), a, b), got);
      end
    end
    for (int i = 0; i < 10; i++) begin
      load_reg(5'd1, classes[i]);
      issue_instr(fp_instr(f7_mv_x, 3'd1, 5'd0, 5'd1, 5'd0));
      wb_read(fpu_pkg::reg_xres, got);
      check_word("fclass", ref_fclass(classes[i]), got);
    end
    report_test("compare_classify");
  endtask

  task automatic test_forwarding();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] x;
    logic [31:0] got;
    test_start = errors;
    for (int i = 0; i < 3; i++) begin
      a = $urandom;
      b = $urandom;
      x = ref_sgnj(3'd2, a, b);
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      load_reg(5'd3, ~x); // Stale value the producer must replace
      issue_instr(fp_instr(f7_sgnj, 3'd2, 5'd3, 5'd1, 5'd2));
      issue_instr(fp_instr(f7_sgnj, 3'd1, 5'd4, 5'd3, 5'd3)); // Back to back
      read_reg(5'd4, got);
      check_word("f4 chain via rs1", ref_sgnj(3'd1, x, x), got);
      load_reg(5'd3, ~x);
      issue_instr(fp_instr(f7_sgnj, 3'd2, 5'd3, 5'd1, 5'd2));
      issue_instr(fp_instr(f7_sgnj, 3'd0, 5'd5, 5'd1, 5'd3));
      read_reg(5'd5, got);
      check_word("f5 chain via rs2", ref_sgnj(3'd0, a, x), got);
    end
    report_test("forwarding");
  endtask

  task automatic test_illegal();
    logic [31:0] words [3];
    logic [31:0] value;
    logic [31:0] status;
    logic [31:0] got;
    test_start = errors;
    words[0] = fp_instr(f7_fadd, 3'd0, 5'd5, 5'd1, 5'd2);
    words[1] = {12'h000, 5'd1, 3'b010, 5'd5, op_load_fp}; // flw f5, 0(x1)
    words[2] = fp_instr(f7_unused, 3'd0, 5'd5, 5'd1, 5'd2);
    for (int i = 0; i < 3; i++) begin
      value = $urandom;
      load_reg(5'd5, value);
      issue_instr(words[i]);
      wb_read(fpu_pkg::reg_status, status);
      check_word("status illegal bit", 32'h1, {31'b0, status[0]});
      read_reg(5'd5, got);
      check_word("f5 after illegal", value, got);
      wb_write(fpu_pkg::reg_status, 32'h0);
      wb_read(fpu_pkg::reg_status, status);
      check_word("status after clear", 32'h0, {31'b0, status[0]});
    end
    report_test("illegal");
  endtask

  initial begin
    void'($urandom(92877));
    checks     = 0;
    errors     = 0;
    test_start = 0;
    rst_n_i    = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    repeat (8) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    test_move_round_trip();
    test_sign_injection();
    test_min_max();
    test_compare_classify();
    test_forwarding();
    test_illegal();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
fpu_pkg.sv
fpu_result_if.sv
fpu_decode.sv
fpu_register.sv
fpu_forwarding.sv
fpu_execute.sv
fpu_wb_slave.sv
fpu_top.sv
tb_fpu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_fpu
RTL_TOP    ?= fpu_top
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation finished: PASS
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
